// ==== des_defs.svh ====
`ifndef DES_DEFS_SVH
`define DES_DEFS_SVH

`define DES_BLOCK_W     64   // plaintext, ciphertext and key
`define DES_HALF_W      32   // L and R halves
`define DES_CD_W        56   // C and D key registers after PC1
`define DES_SUBKEY_W    48   // round subkey, also the expanded half
`define DES_SBOX_IN_W   6
`define DES_SBOX_OUT_W  4
`define DES_ROUNDS      16

// clock edges from the datin edge to the e update
`define DES_LATENCY     6

`endif

// ==== des_pkg.sv ====
`include "des_defs.svh"

package des_pkg;

    typedef logic [`DES_BLOCK_W-1:0]    des_block_t;
    typedef logic [`DES_HALF_W-1:0]     des_half_t;
    typedef logic [`DES_CD_W-1:0]       des_cd_t;
    typedef logic [`DES_SUBKEY_W-1:0]   des_subkey_t;
    typedef logic [`DES_SBOX_IN_W-1:0]  des_sbox_in_t;
    typedef logic [`DES_SBOX_OUT_W-1:0] des_sbox_out_t;

    // each value names the last round finished
    typedef enum logic [2:0] {
        st_idle,
        st_r2,     // IP and rounds 1-2 done
        st_r5,
        st_r8,
        st_r11,
        st_r14     // last cycle does rounds 15-16
    } des_state_t;

endpackage

// ==== des_sbox.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_sbox
    import des_pkg::*;
#(
    parameter int SBOX_NUM = 1
) (
    input  des_sbox_in_t  sin,
    output des_sbox_out_t sout
);

    // four rows of sixteen nibbles, column 0 in the top nibble of each row
    function automatic logic [255:0] sbox_table(input int num);
        case (num)
            1: return {64'hE4D12FB83A6C5907, 64'h0F74E2D1A6CB9538,
                       64'h41E8D62BFC973A50, 64'hFC8249175B3EA06D};
            2: return {64'hF18E6B34972DC05A, 64'h3D47F28EC01A69B5,
                       64'h0E7BA4D158C6932F, 64'hD8A13F42B67C05E9};
            3: return {64'hA09E63F51DC7B428, 64'hD709346A285ECBF1,
                       64'hD6498F30B12C5AE7, 64'h1AD069874FE3B52C};
            4: return {64'h7DE3069A1285BC4F, 64'hD8B56F03472C1AE9,
                       64'hA690CB7DF13E5284, 64'h3F06A1D8945BC72E};
            5: return {64'h2C417AB6853FD0E9, 64'hEB2C47D150FA3986,
                       64'h421BAD78F9C5630E, 64'hB8C71E2D6F09A453};
            6: return {64'hC1AF92680D34E75B, 64'hAF427C9561DE0B38,
                       64'h9EF528C3704A1DB6, 64'h432C95FABE17608D};
            7: return {64'h4B2EF08D3C975A61, 64'hD0B7491AE35C2F86,
                       64'h14BDC37EAF680592, 64'h6BD814A7950FE23C};
            8: return {64'hD2846FB1A93E50C7, 64'h1FD8A374C56B0E92,
                       64'h7B419CE206ADF358, 64'h21E74A8DFC90356B};
            default: return '0;
        endcase
    endfunction

    localparam logic [255:0] SBOX_ROWS = sbox_table(SBOX_NUM);

    logic [`DES_SBOX_IN_W-1:0] lut_idx;

    // outer bits pick the row, inner four the column
    assign lut_idx = {sin[`DES_SBOX_IN_W-1], sin[0], sin[`DES_SBOX_IN_W-2:1]};
    assign sout    = SBOX_ROWS[(63 - lut_idx) * `DES_SBOX_OUT_W +: `DES_SBOX_OUT_W];

endmodule

// ==== des_round_f.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_round_f
    import des_pkg::*;
(
    input  des_block_t  din,
    input  des_subkey_t subkey,
    output des_block_t  dout
);

    localparam int E_TBL [`DES_SUBKEY_W] = '{
        32,  1,  2,  3,  4,  5,
         4,  5,  6,  7,  8,  9,
         8,  9, 10, 11, 12, 13,
        12, 13, 14, 15, 16, 17,
        16, 17, 18, 19, 20, 21,
        20, 21, 22, 23, 24, 25,
        24, 25, 26, 27, 28, 29,
        28, 29, 30, 31, 32,  1
    };

    localparam int P_TBL [`DES_HALF_W] = '{
        16,  7, 20, 21, 29, 12, 28, 17,
         1, 15, 23, 26,  5, 18, 31, 10,
         2,  8, 24, 14, 32, 27,  3,  9,
        19, 13, 30,  6, 22, 11,  4, 25
    };

    des_half_t   l_half;
    des_half_t   r_half;
    des_subkey_t mixed;
    des_half_t   s_out;
    des_half_t   p_out;

    function automatic des_subkey_t expand(input des_half_t x);
        des_subkey_t r;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            r[`DES_SUBKEY_W-1-i] = x[`DES_HALF_W - E_TBL[i]];
        end
        return r;
    endfunction

    function automatic des_half_t p_perm(input des_half_t x);
        des_half_t r;
        for (int i = 0; i < `DES_HALF_W; i++) begin
            r[`DES_HALF_W-1-i] = x[`DES_HALF_W - P_TBL[i]];
        end
        return r;
    endfunction

    assign l_half = din[`DES_BLOCK_W-1:`DES_HALF_W];
    assign r_half = din[`DES_HALF_W-1:0];
    assign mixed  = expand(r_half) ^ subkey;

    // S1 takes the top six bits
    for (genvar g = 0; g < 8; g++) begin : g_sbox
        des_sbox #(
            .SBOX_NUM (g + 1)
        ) u_sbox (
            .sin  (mixed[`DES_SUBKEY_W-1-g*`DES_SBOX_IN_W -: `DES_SBOX_IN_W]),
            .sout (s_out[`DES_HALF_W-1-g*`DES_SBOX_OUT_W -: `DES_SBOX_OUT_W])
        );
    end

    assign p_out = p_perm(s_out);
    assign dout  = {r_half, l_half ^ p_out};   // halves swapped

endmodule

// ==== des_key_schedule.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_key_schedule
    import des_pkg::*;
(
    input  logic        ck,
    input  logic        rst_n,
    input  logic        keyin,
    input  logic        f,           // 1 encrypt, 0 decrypt
    input  des_block_t  k,
    output des_subkey_t subkeys [`DES_ROUNDS]
);

    localparam int CD_HALF_W = `DES_CD_W / 2;

    localparam int PC1_TBL [`DES_CD_W] = '{
        57, 49, 41, 33, 25, 17,  9,
         1, 58, 50, 42, 34, 26, 18,
        10,  2, 59, 51, 43, 35, 27,
        19, 11,  3, 60, 52, 44, 36,
        63, 55, 47, 39, 31, 23, 15,
         7, 62, 54, 46, 38, 30, 22,
        14,  6, 61, 53, 45, 37, 29,
        21, 13,  5, 28, 20, 12,  4
    };

    localparam int PC2_TBL [`DES_SUBKEY_W] = '{
        14, 17, 11, 24,  1,  5,
         3, 28, 15,  6, 21, 10,
        23, 19, 12,  4, 26,  8,
        16,  7, 27, 20, 13,  2,
        41, 52, 31, 37, 47, 55,
        30, 40, 51, 45, 33, 48,
        44, 49, 39, 56, 34, 53,
        46, 42, 50, 36, 29, 32
    };

    localparam int SHIFT_TBL [`DES_ROUNDS] = '{1, 1, 2, 2, 2, 2, 2, 2, 1, 2, 2, 2, 2, 2, 2, 1};

    des_subkey_t round_key [`DES_ROUNDS];   // ascending round order

    function automatic des_cd_t pc1(input des_block_t key);
        des_cd_t r;
        for (int i = 0; i < `DES_CD_W; i++) begin
            r[`DES_CD_W-1-i] = key[`DES_BLOCK_W - PC1_TBL[i]];
        end
        return r;
    endfunction

    function automatic des_subkey_t pc2(input des_cd_t cd);
        des_subkey_t r;
        for (int i = 0; i < `DES_SUBKEY_W; i++) begin
            r[`DES_SUBKEY_W-1-i] = cd[`DES_CD_W - PC2_TBL[i]];
        end
        return r;
    endfunction

    function automatic logic [CD_HALF_W-1:0] rotl(input logic [CD_HALF_W-1:0] x,
                                                  input int n);
        if (n == 1) begin
            return {x[CD_HALF_W-2:0], x[CD_HALF_W-1]};
        end
        return {x[CD_HALF_W-3:0], x[CD_HALF_W-1 -: 2]};
    endfunction

    // walk C and D through all sixteen shifts in one cycle
    always_comb begin
        des_cd_t cd;
        cd = pc1(k);
        for (int r = 0; r < `DES_ROUNDS; r++) begin
            cd = {rotl(cd[`DES_CD_W-1:CD_HALF_W], SHIFT_TBL[r]),
                  rotl(cd[CD_HALF_W-1:0], SHIFT_TBL[r])};
            round_key[r] = pc2(cd);
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            for (int r = 0; r < `DES_ROUNDS; r++) begin
                subkeys[r] <= '0;
            end
        end else if (keyin) begin
            for (int r = 0; r < `DES_ROUNDS; r++) begin
                subkeys[r] <= f ? round_key[r] : round_key[`DES_ROUNDS-1-r];
            end
        end
    end

endmodule

// ==== des_round_engine.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_round_engine
    import des_pkg::*;
(
    input  logic        ck,
    input  logic        rst_n,
    input  logic        datin,
    input  des_block_t  p,
    input  des_subkey_t subkeys [`DES_ROUNDS],
    output des_block_t  round_out,
    output logic        block_done
);

    localparam int IP_TBL [`DES_BLOCK_W] = '{
        58, 50, 42, 34, 26, 18, 10,  2,
        60, 52, 44, 36, 28, 20, 12,  4,
        62, 54, 46, 38, 30, 22, 14,  6,
        64, 56, 48, 40, 32, 24, 16,  8,
        57, 49, 41, 33, 25, 17,  9,  1,
        59, 51, 43, 35, 27, 19, 11,  3,
        61, 53, 45, 37, 29, 21, 13,  5,
        63, 55, 47, 39, 31, 23, 15,  7
    };

    des_state_t state;
    des_block_t round_q;
    des_block_t rnd_in;
    des_block_t rnd_a;
    des_block_t rnd_b;
    des_block_t rnd_c;
    logic [3:0] key_base;

    function automatic des_block_t init_perm(input des_block_t blk);
        des_block_t r;
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            r[`DES_BLOCK_W-1-i] = blk[`DES_BLOCK_W - IP_TBL[i]];
        end
        return r;
    endfunction

    assign rnd_in = (state == st_idle) ? init_perm(p) : round_q;

    always_comb begin
        case (state)
            st_r2:   key_base = 4'd2;
            st_r5:   key_base = 4'd5;
            st_r8:   key_base = 4'd8;
            st_r11:  key_base = 4'd11;
            st_r14:  key_base = 4'd14;
            default: key_base = 4'd0;
        endcase
    end

    des_round_f u_rnd0 (
        .din    (rnd_in),
        .subkey (subkeys[key_base]),
        .dout   (rnd_a)
    );

    des_round_f u_rnd1 (
        .din    (rnd_a),
        .subkey (subkeys[key_base + 4'd1]),
        .dout   (rnd_b)
    );

    // key index wraps in st_r14, third round result unused there
    des_round_f u_rnd2 (
        .din    (rnd_b),
        .subkey (subkeys[key_base + 4'd2]),
        .dout   (rnd_c)
    );

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            case (state)
                st_idle: begin
                    if (datin) begin
                        state <= st_r2;
                    end
                end
                st_r2:   state <= st_r5;
                st_r5:   state <= st_r8;
                st_r8:   state <= st_r11;
                st_r11:  state <= st_r14;
                default: state <= st_idle;   // rounds 15-16 done
            endcase
        end
    end

    always_ff @(posedge ck) begin
        if (state == st_idle) begin
            if (datin) begin
                round_q <= rnd_b;   // IP and rounds 1-2
            end
        end else begin
            round_q <= rnd_c;
        end
    end

    assign round_out  = rnd_b;
    assign block_done = (state == st_r14);

endmodule

// ==== des_output_perm.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_output_perm
    import des_pkg::*;
(
    input  logic       ck,
    input  logic       rst_n,
    input  logic       block_done,
    input  des_block_t round_out,
    output des_block_t e
);

    localparam int FP_TBL [`DES_BLOCK_W] = '{
        40,  8, 48, 16, 56, 24, 64, 32,
        39,  7, 47, 15, 55, 23, 63, 31,
        38,  6, 46, 14, 54, 22, 62, 30,
        37,  5, 45, 13, 53, 21, 61, 29,
        36,  4, 44, 12, 52, 20, 60, 28,
        35,  3, 43, 11, 51, 19, 59, 27,
        34,  2, 42, 10, 50, 18, 58, 26,
        33,  1, 41,  9, 49, 17, 57, 25
    };

    des_block_t preout;
    des_block_t fp_blk;

    // R16 L16
    assign preout = {round_out[`DES_HALF_W-1:0], round_out[`DES_BLOCK_W-1:`DES_HALF_W]};

    always_comb begin
        for (int i = 0; i < `DES_BLOCK_W; i++) begin
            fp_blk[`DES_BLOCK_W-1-i] = preout[`DES_BLOCK_W - FP_TBL[i]];
        end
    end

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            e <= '0;
        end else if (block_done) begin
            e <= fp_blk;   // held until the next block
        end
    end

endmodule

// ==== des_core.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_core
    import des_pkg::*;
(
    input  logic       ck,
    input  logic       rst_n,
    input  logic       keyin,
    input  logic       f,
    input  logic       datin,
    input  des_block_t k,
    input  des_block_t p,
    output des_block_t e
);

    des_subkey_t subkeys [`DES_ROUNDS];   // entry 0 used first
    des_block_t  round_out;
    logic        block_done;

    des_key_schedule u_key (
        .ck      (ck),
        .rst_n   (rst_n),
        .keyin   (keyin),
        .f       (f),
        .k       (k),
        .subkeys (subkeys)
    );

    des_round_engine u_eng (
        .ck         (ck),
        .rst_n      (rst_n),
        .datin      (datin),
        .p          (p),
        .subkeys    (subkeys),
        .round_out  (round_out),
        .block_done (block_done)
    );

    des_output_perm u_out (
        .ck         (ck),
        .rst_n      (rst_n),
        .block_done (block_done),
        .round_out  (round_out),
        .e          (e)
    );

endmodule

// ==== des_asserts.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module des_asserts
    import des_pkg::*;
(
    input logic       ck,
    input logic       rst_n,
    input logic       keyin,
    input logic       datin,
    input des_block_t e
);

    localparam logic [2:0] LAST_CNT = 3'(`DES_LATENCY - 1);

    logic [2:0] busy_cnt;   // edges since the accepted datin, 0 when idle

    always_ff @(posedge ck) begin
        if (!rst_n) begin
            busy_cnt <= '0;
        end else if (busy_cnt == 3'd0) begin
            if (datin) begin
                busy_cnt <= 3'd1;
            end
        end else if (busy_cnt == LAST_CNT) begin
            busy_cnt <= 3'd0;   // e updates on this edge
        end else begin
            busy_cnt <= busy_cnt + 3'd1;
        end
    end

    a_e_timing : assert property (@(posedge ck) disable iff (!rst_n)
        (busy_cnt != LAST_CNT) |=> $stable(e))
        else $error("e changed outside the result edge of a block");

    a_no_key_busy : assert property (@(posedge ck) disable iff (!rst_n)
        (busy_cnt != 3'd0) |-> !keyin)
        else $error("keyin strobe while a block is in progress");

    a_e_reset : assert property (@(posedge ck)
        !rst_n |=> (e == '0))
        else $error("e not cleared by reset");

endmodule

bind des_core des_asserts u_asserts (
    .ck    (ck),
    .rst_n (rst_n),
    .keyin (keyin),
    .datin (datin),
    .e     (e)
);

// ==== tb_des.sv ====
`timescale 1ns/10ps
`include "des_defs.svh"

module tb_des
    import des_pkg::*;
();

    localparam int N_VEC     = 13;
    localparam int N_RAND    = 40;
    localparam int CK_PERIOD = 8;
    localparam int WATCHDOG_CYCLES = (N_VEC + N_RAND) * (`DES_LATENCY + 4) * 2;

    typedef struct packed {
        logic       load;      // reload key before the block
        logic       mid;       // stray datin while busy
        logic       dir;       // 1 encrypt, 0 decrypt
        des_block_t key;
        des_block_t din;
        des_block_t exp_out;
    } vec_t;

    logic       ck;
    logic       rst_n;
    logic       keyin;
    logic       f;
    logic       datin;
    des_block_t k;
    des_block_t p;
    des_block_t e;

    logic [31:0] lcg_state = 32'h71744237;

    vec_t vec_tbl [N_VEC] = '{
        '{1'b1, 1'b0, 1'b1, 64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405},
        '{1'b1, 1'b0, 1'b0, 64'h133457799BBCDFF1, 64'h85E813540F0AB405, 64'h0123456789ABCDEF},
        '{1'b1, 1'b0, 1'b1, 64'h0E329232EA6D0D73, 64'h8787878787878787, 64'h0000000000000000},
        '{1'b1, 1'b0, 1'b0, 64'h0E329232EA6D0D73, 64'h0000000000000000, 64'h8787878787878787},
        '{1'b1, 1'b0, 1'b1, 64'h0000000000000000, 64'h0000000000000000, 64'h8CA64DE9C1B123A7},
        '{1'b1, 1'b0, 1'b0, 64'h0000000000000000, 64'h8CA64DE9C1B123A7, 64'h0000000000000000},
        '{1'b1, 1'b0, 1'b1, 64'hFFFFFFFFFFFFFFFF, 64'hFFFFFFFFFFFFFFFF, 64'h7359B2163E4EDC58},
        '{1'b1, 1'b1, 1'b0, 64'hFFFFFFFFFFFFFFFF, 64'h7359B2163E4EDC58, 64'hFFFFFFFFFFFFFFFF},
        '{1'b1, 1'b0, 1'b1, 64'h0123456789ABCDEF, 64'h4E6F772069732074, 64'h3FA40E8A984D4815},
        '{1'b0, 1'b0, 1'b1, 64'h0123456789ABCDEF, 64'h68652074696D6520, 64'h6A271787AB8883F9},
        '{1'b0, 1'b1, 1'b1, 64'h0123456789ABCDEF, 64'h666F7220616C6C20, 64'h893D51EC4B563B53},
        '{1'b1, 1'b0, 1'b1, 64'h133457799BBCDFF1, 64'h0123456789ABCDEF, 64'h85E813540F0AB405},
        '{1'b1, 1'b0, 1'b0, 64'h0123456789ABCDEF, 64'h3FA40E8A984D4815, 64'h4E6F772069732074}
    };

    des_core u_dut (
        .ck    (ck),
        .rst_n (rst_n),
        .keyin (keyin),
        .f     (f),
        .datin (datin),
        .k     (k),
        .p     (p),
        .e     (e)
    );

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic des_block_t lcg_block();
        des_block_t b;
        b[63:32] = lcg_next();
        b[31:0]  = lcg_next();
        return b;
    endfunction

    task automatic check_block(input des_block_t got, input des_block_t exp, input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s got %h expected %h", $time, what, got, exp);
            $display("tests failed");
            $fatal(1, "mismatch on e");
        end
    endtask

    // optional key load, one datin strobe, then wait out the fixed latency
    task automatic run_block(input logic load, input des_block_t key, input logic dir,
                             input des_block_t din, input logic mid,
                             output des_block_t result);
        des_block_t prev;
        prev = e;
        if (load) begin
            keyin = 1'b1;
            k     = key;
            f     = dir;
            @(posedge ck);
            #1;
            keyin = 1'b0;
        end
        datin = 1'b1;
        p     = din;
        @(posedge ck);   // edge D
        #1;
        datin = 1'b0;
        p     = lcg_block();
        for (int i = 1; i < `DES_LATENCY; i++) begin
            check_block(e, prev, "e changed before the result edge");
            datin = mid && (i == 2);   // ignored while busy
            @(posedge ck);
            #1;
        end
        result = e;
    endtask

    initial begin
        ck = 1'b0;
        forever #(CK_PERIOD / 2) ck = ~ck;
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge ck);
        $display("simulation timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("tests failed");
        $fatal(1, "watchdog expired");
    end

    initial begin
        des_block_t got;
        des_block_t rt_key;
        des_block_t rt_pt;
        des_block_t rt_ct;
        des_block_t rt_back;
        rst_n = 1'b0;
        keyin = 1'b0;
        f     = 1'b0;
        datin = 1'b0;
        k     = '0;
        p     = '0;
        repeat (4) @(posedge ck);
        #1;
        rst_n = 1'b1;
        check_block(e, '0, "e after reset");

        for (int n = 0; n < N_VEC; n++) begin
            run_block(vec_tbl[n].load, vec_tbl[n].key, vec_tbl[n].dir, vec_tbl[n].din,
                      vec_tbl[n].mid, got);
            check_block(got, vec_tbl[n].exp_out, $sformatf("vector %0d", n));
            repeat (2) begin
                @(posedge ck);
                #1;
                check_block(e, vec_tbl[n].exp_out, "e not held across idle cycles");
            end
        end

        for (int t = 0; t < N_RAND; t++) begin
            rt_key = lcg_block();
            rt_pt  = lcg_block();
            run_block(1'b1, rt_key, 1'b1, rt_pt, 1'b0, rt_ct);
            run_block(1'b1, rt_key, 1'b0, rt_ct, 1'b0, rt_back);
            check_block(rt_back, rt_pt, $sformatf("round trip trial %0d", t));
        end

        $display("all tests passed");
        $finish;
    end

endmodule

// ==== des_core.f ====
+incdir+.
des_pkg.sv
des_sbox.sv
des_round_f.sv
des_key_schedule.sv
des_round_engine.sv
des_output_perm.sv
des_core.sv
des_asserts.sv
tb_des.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the DES core testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f des_core.f --top-module tb_des -o sim_tb_des
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/sim_tb_des > "$LOG" 2>&1
run_status=$?
cat "$LOG"
if [ $run_status -ne 0 ]; then
    echo "simulation exited with status $run_status"
    exit 1
fi

if grep -q "^all tests passed$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
